/* files.f */
+incdir+src
src/emu_pkg.sv
src/csr_write_port.sv
src/csr_read_port.sv
src/run_control.sv
src/emu_ctrl_top.sv
tests/emu_ctrl_asserts.sv
tests/emu_ctrl_tb.sv

/* src/csr_read_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "emu_macros.svh"

module csr_read_port (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      arvalid,
    output logic                     arready,
    input  wire emu_pkg::csr_addr_t  araddr,
    output logic                     rvalid,
    input  wire                      rready,
    output emu_pkg::csr_data_t       rdata,
    output logic [1:0]               rresp,
    input  wire emu_pkg::emu_regs_t  regs
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    rd_state_t          state;
    emu_pkg::csr_addr_t addr_q;
    emu_pkg::csr_data_t rdata_q;
    emu_pkg::csr_data_t mux_data;
    emu_pkg::csr_data_t stat_word;

    assign arready = (state == RD_IDLE);
    assign rvalid  = (state == RD_DATA);
    assign rdata   = rdata_q;
    assign rresp   = `EMU_RESP_OKAY;

    always_comb begin
        stat_word = '0;
        stat_word[`EMU_STAT_PAUSE_BIT] = regs.pause;
        stat_word[`EMU_STAT_RST_BIT]   = regs.design_rst;
        stat_word[`EMU_STAT_STEP_BIT]  = regs.step_trig;
    end

    // Unmapped offsets fall through to zero
    always_comb begin
        case (addr_q)
            `EMU_STAT:      mux_data = stat_word;
            `EMU_TRIG_STAT: mux_data = regs.trig_stat;
            `EMU_CYCLE_LO:  mux_data = regs.cycle[`EMU_DATA_W-1:0];
            `EMU_CYCLE_HI:  mux_data = regs.cycle[`EMU_CYCLE_W-1:`EMU_DATA_W];
            `EMU_STEP:      mux_data = regs.step;
            default:        mux_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            addr_q <= araddr;
        end
        if (state == RD_ADDR) begin
            rdata_q <= mux_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: if (arvalid) state <= RD_ADDR;
                RD_ADDR: state <= RD_DATA;
                // Word holds until the master takes it
                RD_DATA: if (rready) state <= RD_IDLE;
                default: state <= RD_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/csr_write_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "emu_macros.svh"

module csr_write_port (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      awvalid,
    output logic                     awready,
    input  wire emu_pkg::csr_addr_t  awaddr,
    input  wire                      wvalid,
    output logic                     wready,
    input  wire emu_pkg::csr_data_t  wdata,
    input  wire [3:0]                wstrb,
    output logic                     bvalid,
    input  wire                      bready,
    output logic [1:0]               bresp,
    output emu_pkg::csr_write_t      wr
);

    emu_pkg::csr_addr_t addr_q;
    emu_pkg::csr_data_t data_q;
    logic               addr_held;
    logic               data_held;
    logic               strb_err;
    logic               wr_valid;
    logic               issue;
    logic               resp_err;
    logic               resp_valid;

    assign awready = !addr_held && !issue && !resp_valid;
    assign wready  = !data_held;
    assign bvalid  = resp_valid;
    assign bresp   = resp_err ? `EMU_RESP_SLVERR : `EMU_RESP_OKAY;

    // Holding regs stay put through the pulse cycle, so they double as the payload
    assign wr = '{valid: wr_valid, addr: addr_q, data: data_q};

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            data_q <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_held  <= 1'b0;
            data_held  <= 1'b0;
            strb_err   <= 1'b0;
            wr_valid   <= 1'b0;
            issue      <= 1'b0;
            resp_err   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;
            if (awvalid && awready) begin
                addr_held <= 1'b1;
            end
            if (wvalid && wready) begin
                data_held <= 1'b1;
                strb_err  <= !(&wstrb);
            end
            // Both halves present, fire the write unless strobes were partial
            if (addr_held && data_held) begin
                addr_held <= 1'b0;
                data_held <= 1'b0;
                wr_valid  <= !strb_err;
                issue     <= 1'b1;
                resp_err  <= strb_err;
            end
            // Response goes out as the register updates
            if (issue) begin
                issue      <= 1'b0;
                resp_valid <= 1'b1;
            end
            if (bvalid && bready) begin
                resp_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/emu_ctrl_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "emu_macros.svh"

module emu_ctrl_top (
    input  wire                      clk,
    input  wire                      rst,
    // AXI4-Lite slave
    input  wire                      awvalid,
    output logic                     awready,
    input  wire emu_pkg::csr_addr_t  awaddr,
    input  wire                      wvalid,
    output logic                     wready,
    input  wire emu_pkg::csr_data_t  wdata,
    input  wire [3:0]                wstrb,
    output logic                     bvalid,
    input  wire                      bready,
    output logic [1:0]               bresp,
    input  wire                      arvalid,
    output logic                     arready,
    input  wire emu_pkg::csr_addr_t  araddr,
    output logic                     rvalid,
    input  wire                      rready,
    output emu_pkg::csr_data_t       rdata,
    output logic [1:0]               rresp,
    // Emulated design pins
    input  wire emu_pkg::trig_t      dut_trig,
    output logic                     dut_clk_en,
    output logic                     dut_rst
);

    emu_pkg::csr_write_t wr;
    emu_pkg::emu_regs_t  regs;

    csr_write_port csr_write_port_i (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .wr      (wr)
    );

    csr_read_port csr_read_port_i (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .regs    (regs)
    );

    run_control run_control_i (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .dut_trig   (dut_trig),
        .regs       (regs),
        .dut_clk_en (dut_clk_en),
        .dut_rst    (dut_rst)
    );

endmodule

`default_nettype wire

/* src/emu_macros.svh */
`ifndef EMU_MACROS_SVH
`define EMU_MACROS_SVH

// Bus and counter widths
`define EMU_ADDR_W          12
`define EMU_DATA_W          32
`define EMU_CYCLE_W         64
`define EMU_TRIG_W          32

// Register map
`define EMU_STAT            12'h000
`define EMU_TRIG_STAT       12'h004
`define EMU_CYCLE_LO        12'h008
`define EMU_CYCLE_HI        12'h00C
`define EMU_STEP            12'h010

// EMU_STAT bit positions, bit 31 is read-only
`define EMU_STAT_PAUSE_BIT  0
`define EMU_STAT_RST_BIT    1
`define EMU_STAT_STEP_BIT   31

// AXI response codes
`define EMU_RESP_OKAY       2'd0
`define EMU_RESP_SLVERR     2'd2

`endif

/* src/emu_pkg.sv */
`default_nettype none

`include "emu_macros.svh"

package emu_pkg;

    typedef logic [`EMU_ADDR_W-1:0]  csr_addr_t;
    typedef logic [`EMU_DATA_W-1:0]  csr_data_t;
    typedef logic [`EMU_CYCLE_W-1:0] cycle_t;
    typedef logic [`EMU_TRIG_W-1:0]  trig_t;

    // One register write, valid is a single-cycle pulse
    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        csr_data_t data;
    } csr_write_t;

    // Everything the read port can return
    typedef struct packed {
        logic      pause;
        logic      design_rst;
        logic      step_trig;
        trig_t     trig_stat;
        cycle_t    cycle;
        csr_data_t step;
    } emu_regs_t;

endpackage

`default_nettype wire

/* src/run_control.sv */
`timescale 1ns/10ps
`default_nettype none

`include "emu_macros.svh"

module run_control (
    input  wire                       clk,
    input  wire                       rst,
    input  wire emu_pkg::csr_write_t  wr,
    input  wire emu_pkg::trig_t       dut_trig,
    output emu_pkg::emu_regs_t        regs,
    output logic                      dut_clk_en,
    output logic                      dut_rst
);

    logic               pause;
    logic               design_rst;
    logic               step_flag;
    emu_pkg::trig_t     trig_stat;
    emu_pkg::cycle_t    cycle;
    emu_pkg::csr_data_t step;
    emu_pkg::csr_data_t step_next;
    logic               step_trig;
    logic               trigger;
    logic               wr_stat;
    logic               wr_cycle_lo;
    logic               wr_cycle_hi;
    logic               wr_step;

    // Write address decode
    assign wr_stat     = wr.valid && (wr.addr == `EMU_STAT);
    assign wr_cycle_lo = wr.valid && (wr.addr == `EMU_CYCLE_LO);
    assign wr_cycle_hi = wr.valid && (wr.addr == `EMU_CYCLE_HI);
    assign wr_step     = wr.valid && (wr.addr == `EMU_STEP);

    // Countdown only moves while running and sticks at zero
    always_comb begin
        if (pause) begin
            step_next = step;
        end else if (step != '0) begin
            step_next = step - 1'b1;
        end else begin
            step_next = '0;
        end
    end

    assign step_trig = (step != '0) && (step_next == '0);
    assign trigger   = step_trig || (|dut_trig);

    always_ff @(posedge clk) begin
        if (rst) begin
            pause      <= 1'b1;
            design_rst <= 1'b1;
            step_flag  <= 1'b0;
            trig_stat  <= '0;
        end else if (trigger) begin
            pause      <= 1'b1;
            step_flag  <= step_trig;
            trig_stat  <= dut_trig;
        end else if (wr_stat) begin
            pause      <= wr.data[`EMU_STAT_PAUSE_BIT];
            design_rst <= wr.data[`EMU_STAT_RST_BIT];
        end
    end

    // Cycle counter, software may only load it while paused
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (!pause) begin
            cycle <= cycle + 1'b1;
        end else begin
            if (wr_cycle_lo) cycle[`EMU_DATA_W-1:0] <= wr.data;
            if (wr_cycle_hi) cycle[`EMU_CYCLE_W-1:`EMU_DATA_W] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (wr_step) begin
            step <= wr.data;
        end else begin
            step <= step_next;
        end
    end

    always_comb begin
        regs.pause      = pause;
        regs.design_rst = design_rst;
        regs.step_trig  = step_flag;
        regs.trig_stat  = trig_stat;
        regs.cycle      = cycle;
        regs.step       = step;
    end

    assign dut_clk_en = !pause;
    assign dut_rst    = design_rst;

endmodule

`default_nettype wire

/* tests/emu_ctrl_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

`include "emu_macros.svh"

module emu_ctrl_asserts (
    input wire                      clk,
    input wire                      rst,
    input wire                      bvalid,
    input wire                      bready,
    input wire                      rvalid,
    input wire                      rready,
    input wire emu_pkg::csr_data_t  rdata,
    input wire                      dut_clk_en,
    input wire emu_pkg::csr_write_t wr,
    input wire emu_pkg::trig_t      dut_trig
);

    int fail_count = 0;

    bresp_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    rdata_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $error("read response changed before rready");
            fail_count++;
        end

    // A trigger or a pause write stops the design clock at the next edge
    pause_gate: assert property (@(posedge clk) disable iff (rst)
        (|dut_trig) ||
        (wr.valid && wr.addr == `EMU_STAT && wr.data[`EMU_STAT_PAUSE_BIT])
        |=> !dut_clk_en)
        else begin
            $error("dut_clk_en high after the paused bit was set");
            fail_count++;
        end

    wr_pulse: assert property (@(posedge clk) disable iff (rst)
        wr.valid |=> !wr.valid)
        else begin
            $error("register write pulse lasted two cycles");
            fail_count++;
        end

endmodule

bind emu_ctrl_top emu_ctrl_asserts emu_ctrl_asserts_i (
    .clk(clk), .rst(rst), .bvalid(bvalid), .bready(bready),
    .rvalid(rvalid), .rready(rready), .rdata(rdata),
    .dut_clk_en(dut_clk_en), .wr(wr), .dut_trig(dut_trig)
);

`default_nettype wire

/* tests/emu_ctrl_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "emu_macros.svh"

module emu_ctrl_tb;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam logic [11:0] UNMAPPED_ADDR = 12'h100;

    logic clk;
    logic rst;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic awready, wready, bvalid, arready, rvalid;
    emu_pkg::csr_addr_t awaddr, araddr;
    emu_pkg::csr_data_t wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    emu_pkg::trig_t dut_trig;
    logic dut_clk_en, dut_rst;

    // Register model
    logic m_pause, m_rst, m_step_flag;
    logic [31:0] m_trig, m_step;
    logic [63:0] m_cycle;

    // Pending checks for the compare process
    string name_q[$];
    logic [63:0] got_q[$];
    logic [63:0] exp_q[$];

    int error_count = 0;
    int errors_at_start = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    logic [31:0] rng = 32'd15994;

    emu_ctrl_top emu_ctrl_top_i (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .dut_trig(dut_trig), .dut_clk_en(dut_clk_en), .dut_rst(dut_rst)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected read value from the register model
    function automatic logic [31:0] expected_read(input logic [11:0] addr);
        logic [31:0] word;
        word = '0;
        case (addr)
            `EMU_STAT: begin
                word[`EMU_STAT_PAUSE_BIT] = m_pause;
                word[`EMU_STAT_RST_BIT]   = m_rst;
                word[`EMU_STAT_STEP_BIT]  = m_step_flag;
            end
            `EMU_TRIG_STAT: word = m_trig;
            `EMU_CYCLE_LO:  word = m_cycle[31:0];
            `EMU_CYCLE_HI:  word = m_cycle[63:32];
            `EMU_STEP:      word = m_step;
            default:        word = '0;
        endcase
        return word;
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [31:0] data);
        case (addr)
            `EMU_STAT: begin
                m_pause = data[`EMU_STAT_PAUSE_BIT];
                m_rst   = data[`EMU_STAT_RST_BIT];
            end
            `EMU_CYCLE_LO: if (m_pause) m_cycle[31:0] = data;
            `EMU_CYCLE_HI: if (m_pause) m_cycle[63:32] = data;
            `EMU_STEP:     m_step = data;
            default: ;
        endcase
    endtask

    task automatic queue_check(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    task automatic bus_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic aw_done, w_done, aw_hs, w_hs;
        logic [1:0] resp;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        bready  = 1'b1;
        aw_done = 1'b0;
        w_done  = 1'b0;
        while (!(aw_done && w_done)) begin
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(negedge clk);
            if (aw_hs) begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
        end
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
        // Partial strobes must be refused
        queue_check("bresp", resp, (&strb) ? `EMU_RESP_OKAY : `EMU_RESP_SLVERR);
        if (&strb) model_write(addr, data);
    endtask

    task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        queue_check("rresp", resp, `EMU_RESP_OKAY);
    endtask

    task automatic read_check(input logic [11:0] addr);
        logic [31:0] data;
        bus_read(addr, data);
        queue_check($sformatf("rdata@%03h", addr), data, expected_read(addr));
    endtask

    task automatic end_test(input string name);
        int fails;
        @(posedge clk);
        #1;
        fails = error_count - errors_at_start;
        errors_at_start = error_count;
        if (fails == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: %0d wrong value(s)", name, fails);
        end
    endtask

    // Compare process
    initial begin
        forever begin
            @(posedge clk);
            while (got_q.size() > 0) begin
                assert (got_q[0] == exp_q[0]) else begin
                    $display("[ERROR] %s got 0x%0h expected 0x%0h",
                             name_q[0], got_q[0], exp_q[0]);
                    error_count++;
                end
                void'(name_q.pop_front());
                void'(got_q.pop_front());
                void'(exp_q.pop_front());
            end
        end
    end

    // Watchdog
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] n, val, lo, hi, first_lo, w;
        logic [63:0] c, pre;
        rst = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        dut_trig = '0;
        m_pause = 1'b1;
        m_rst = 1'b1;
        m_step_flag = 1'b0;
        m_trig = '0;
        m_step = '0;
        m_cycle = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        read_check(`EMU_STAT);
        queue_check("dut_rst", dut_rst, 1);
        queue_check("dut_clk_en", dut_clk_en, 0);
        end_test("test 1 reset state");

        rng = xorshift32(rng);
        bus_write(`EMU_CYCLE_LO, rng, 4'hF);
        rng = xorshift32(rng);
        bus_write(`EMU_CYCLE_HI, rng, 4'hF);
        rng = xorshift32(rng);
        bus_write(`EMU_STEP, rng, 4'hF);
        read_check(`EMU_CYCLE_LO);
        read_check(`EMU_CYCLE_HI);
        read_check(`EMU_STEP);
        read_check(UNMAPPED_ADDR);
        rng = xorshift32(rng);
        bus_write(`EMU_TRIG_STAT, rng, 4'hF);
        read_check(`EMU_TRIG_STAT);
        end_test("test 2 paused read back");

        rng = xorshift32(rng);
        bus_write(`EMU_STEP, rng, 4'b0111);
        read_check(`EMU_STEP);
        end_test("test 3 partial strobe");

        rng = xorshift32(rng);
        c[31:0] = rng;
        rng = xorshift32(rng);
        c[63:32] = rng;
        rng = xorshift32(rng);
        n = (rng % 20) + 1;
        bus_write(`EMU_CYCLE_LO, c[31:0], 4'hF);
        bus_write(`EMU_CYCLE_HI, c[63:32], 4'hF);
        bus_write(`EMU_STEP, n, 4'hF);
        bus_write(`EMU_STAT, 32'h0, 4'hF);
        while (dut_clk_en) @(negedge clk);
        // Countdown ran out, one counter tick per step
        m_pause = 1'b1;
        m_step_flag = 1'b1;
        m_step = '0;
        m_cycle = c + n;
        read_check(`EMU_STAT);
        read_check(`EMU_CYCLE_LO);
        read_check(`EMU_CYCLE_HI);
        read_check(`EMU_STEP);
        queue_check("dut_rst", dut_rst, 0);
        end_test("test 4 single step");

        bus_write(`EMU_STEP, 32'h0, 4'hF);
        bus_write(`EMU_STAT, 32'h0, 4'hF);
        queue_check("dut_clk_en", dut_clk_en, 1);
        rng = xorshift32(rng);
        val = (rng == 0) ? 32'h1 : rng;
        @(negedge clk);
        dut_trig = val;
        @(negedge clk);
        dut_trig = '0;
        // Pause lands on the edge inside the pulse
        m_pause = 1'b1;
        m_step_flag = 1'b0;
        m_trig = val;
        queue_check("dut_clk_en", dut_clk_en, 0);
        read_check(`EMU_TRIG_STAT);
        read_check(`EMU_STAT);
        bus_read(`EMU_CYCLE_LO, first_lo);
        repeat (6) @(negedge clk);
        bus_read(`EMU_CYCLE_LO, lo);
        queue_check("rdata@008", lo, first_lo);
        end_test("test 5 design trigger");

        // Low half starts high, so taking the small running write would move the count back
        rng = xorshift32(rng);
        bus_write(`EMU_CYCLE_HI, rng, 4'hF);
        rng = xorshift32(rng);
        bus_write(`EMU_CYCLE_LO, (rng & 32'h0FFF_FFFF) | 32'h8000_0000, 4'hF);
        pre = m_cycle;
        bus_write(`EMU_STAT, 32'h0, 4'hF);
        rng = xorshift32(rng);
        w = rng & 32'h0FFF_FFFF;
        bus_write(`EMU_CYCLE_LO, w, 4'hF);
        bus_write(`EMU_STAT, 32'h1, 4'hF);
        bus_read(`EMU_CYCLE_LO, lo);
        bus_read(`EMU_CYCLE_HI, hi);
        assert (lo != w) else begin
            $display("Cycle counter accepted a write while the design was running");
            error_count++;
        end
        assert ({hi, lo} >= pre) else begin
            $display("Cycle counter went backwards while the design was running");
            error_count++;
        end
        end_test("test 6 running cycle write");

        $display("Summary: %0d passed, %0d failing, %0d assertion failures",
                 tests_passed, tests_failed, emu_ctrl_top_i.emu_ctrl_asserts_i.fail_count);
        if (tests_failed == 0 && emu_ctrl_top_i.emu_ctrl_asserts_i.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
